// ==== hw/gnn_dp_defines.svh ====
`ifndef GNN_DP_DEFINES_SVH
`define GNN_DP_DEFINES_SVH

// command word from the host
`define CMD_WIDTH 32

// host queue, also the host credit count after reset
`define CMD_QUEUE_DEPTH 8

// processing element credits after reset
`define TASK_CREDITS 4

// reservation station entries
`define STATION_DEPTH 4

// replay iterations, the last one is MAX_REPLAY_ITER-1
`define MAX_REPLAY_ITER 4

// width of pe_idle and bank_busy
`define NUM_PE 4

// configuration field widths
`define FV_WIDTH 5
`define WB_WIDTH 4

`endif

// ==== hw/dp_cmd_pkg.sv ====
`default_nettype none

`include "gnn_dp_defines.svh"

package dp_cmd_pkg;

    // one mask bit per replay iteration
    localparam int iter_mask_w = `MAX_REPLAY_ITER;
    localparam int payload_lo_w = 10;
    localparam int payload_hi_w = `CMD_WIDTH - 2 - iter_mask_w - payload_lo_w;

    typedef enum logic [1:0] {
        op_task         = 2'b00,
        op_replay       = 2'b01,
        op_feat_count   = 2'b10,
        op_weight_bound = 2'b11
    } cmd_op_e;

    // mask sits in bits 13:10 of the word
    typedef struct packed {
        cmd_op_e                   op;
        logic [payload_hi_w-1:0]   payload_hi;
        logic [iter_mask_w-1:0]    iter_mask;
        logic [payload_lo_w-1:0]   payload_lo;
    } task_view_t;

    typedef struct packed {
        cmd_op_e                   op;
        logic [`CMD_WIDTH-3:0]     value;
    } cfg_view_t;

    typedef union packed {
        task_view_t task_view;
        cfg_view_t  cfg_view;
    } cmd_word_u;

endpackage

`default_nettype wire

// ==== hw/dp_task_pkg.sv ====
`default_nettype none

`include "gnn_dp_defines.svh"

package dp_task_pkg;

    // task payload as seen by the station and the PEs
    // opcode stripped, iteration mask kept in place
    typedef logic [`CMD_WIDTH-3:0] task_t;

    // whole command word forwarded to memory
    // deferred tasks and replay words both use it
    typedef logic [`CMD_WIDTH-1:0] mem_pkt_t;

endpackage

`default_nettype wire

// ==== hw/cmd_queue.sv ====
`default_nettype none

`include "gnn_dp_defines.svh"

module cmd_queue (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cmd_in_valid,
    input  dp_cmd_pkg::cmd_word_u cmd_in,
    output logic                  cmd_credit,
    output logic                  head_valid,
    output dp_cmd_pkg::cmd_word_u head_word,
    input  logic                  pop
);
    import dp_cmd_pkg::*;

    localparam int depth = `CMD_QUEUE_DEPTH;
    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    cmd_word_u          mem [depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   count;
    logic               full;
    logic               push;
    logic               take;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full       = (count == cnt_w'(depth));
    assign head_valid = (count != '0);
    assign head_word  = mem[rd_ptr];

    // host owns the credits, a write when full is dropped
    assign push = cmd_in_valid && !full;
    assign take = pop && head_valid;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= cmd_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            cmd_credit <= 1'b0;
        end else begin
            // one credit back per word consumed
            cmd_credit <= take;
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (take) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/dp_decoder.sv ====
`default_nettype none

`include "gnn_dp_defines.svh"

module dp_decoder (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        head_valid,
    input  dp_cmd_pkg::cmd_word_u       head_word,
    output logic                        pop,
    input  logic                        station_full,
    input  logic                        rs_empty,
    output logic                        task_valid,
    output dp_task_pkg::task_t          task_data,
    output logic                        mem_req,
    input  logic                        grant,
    output logic                        mem_valid,
    output dp_task_pkg::mem_pkt_t       mem_pkt,
    input  logic [`NUM_PE-1:0]          bank_busy,
    input  logic [`NUM_PE-1:0]          pe_idle,
    input  logic                        stream_end,
    input  logic                        vertex_done,
    input  logic                        outbuff_available,
    output logic                        cntl_done,
    output logic                        task_complete,
    output logic                        stream_begin,
    output logic [1:0]                  replay_iter,
    output logic [`FV_WIDTH-1:0]        num_fv,
    output logic [`WB_WIDTH-1:0]        weights_boundary
);
    import dp_cmd_pkg::*;
    import dp_task_pkg::*;

    localparam logic [2:0] st_idle          = 3'd0;
    localparam logic [2:0] st_wait_grant    = 3'd1;
    localparam logic [2:0] st_wait_replay   = 3'd2;
    localparam logic [2:0] st_wait_stream   = 3'd3;
    localparam logic [2:0] st_wait_complete = 3'd4;

    localparam logic [1:0] last_iter = 2'(`MAX_REPLAY_ITER - 1);

    logic [2:0] state;
    logic [2:0] state_next;
    mem_pkt_t   pkt_q;
    cmd_op_e    head_op;
    logic       task_hit;
    logic       drained;
    logic       save_pkt;
    logic       load_fv;
    logic       load_wb;
    logic       bump_iter;

    // opcode lies in the same bits for both views
    assign head_op  = head_word.task_view.op;
    assign task_hit = head_word.task_view.iter_mask[replay_iter];
    assign drained  = ~|bank_busy && rs_empty && &pe_idle;

    assign task_data = {head_word.task_view.payload_hi,
                        head_word.task_view.iter_mask,
                        head_word.task_view.payload_lo};

    assign mem_req = (state == st_wait_grant);
    assign mem_pkt = pkt_q;

    always_comb begin
        state_next    = state;
        pop           = 1'b0;
        task_valid    = 1'b0;
        mem_valid     = 1'b0;
        save_pkt      = 1'b0;
        load_fv       = 1'b0;
        load_wb       = 1'b0;
        bump_iter     = 1'b0;
        cntl_done     = 1'b0;
        task_complete = 1'b0;
        case (state)
            st_idle: begin
                if (head_valid) begin
                    case (head_op)
                        op_task: begin
                            if (!task_hit) begin
                                // not for this iteration, defer through memory
                                pop        = 1'b1;
                                save_pkt   = 1'b1;
                                state_next = st_wait_grant;
                            end else if (!station_full) begin
                                pop        = 1'b1;
                                task_valid = 1'b1;
                            end
                        end
                        op_replay: begin
                            pop        = 1'b1;
                            save_pkt   = 1'b1;
                            state_next = st_wait_replay;
                        end
                        op_feat_count: begin
                            pop     = 1'b1;
                            load_fv = 1'b1;
                        end
                        op_weight_bound: begin
                            pop        = 1'b1;
                            load_wb    = 1'b1;
                            state_next = st_wait_stream;
                        end
                    endcase
                end
            end
            st_wait_grant: begin
                if (grant) begin
                    mem_valid  = 1'b1;
                    state_next = st_idle;
                end
            end
            st_wait_replay: begin
                // banks, station and PEs must all be quiet
                if (drained) begin
                    if (replay_iter == last_iter) begin
                        cntl_done  = 1'b1;
                        state_next = st_wait_complete;
                    end else begin
                        mem_valid  = 1'b1;
                        bump_iter  = 1'b1;
                        state_next = st_wait_stream;
                    end
                end
            end
            st_wait_stream: begin
                if (stream_end) begin
                    state_next = st_idle;
                end
            end
            st_wait_complete: begin
                // held here until reset
                task_complete = vertex_done && outbuff_available;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state            <= st_idle;
            replay_iter      <= '0;
            num_fv           <= '0;
            weights_boundary <= '0;
            stream_begin     <= 1'b0;
        end else begin
            state        <= state_next;
            stream_begin <= load_fv;
            if (load_fv) begin
                num_fv <= head_word.cfg_view.value[`FV_WIDTH-1:0];
            end
            if (load_wb) begin
                weights_boundary <= head_word.cfg_view.value[`WB_WIDTH-1:0];
            end
            if (bump_iter) begin
                replay_iter <= replay_iter + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (save_pkt) begin
            pkt_q <= head_word;
        end
    end

endmodule

`default_nettype wire

// ==== hw/task_station.sv ====
`default_nettype none

`include "gnn_dp_defines.svh"

module task_station (
    input  logic               clk,
    input  logic               reset,
    input  logic               task_valid,
    input  dp_task_pkg::task_t task_data,
    output logic               station_full,
    output logic               rs_empty,
    output logic               pe_task_valid,
    output dp_task_pkg::task_t pe_task,
    input  logic               pe_credit
);
    import dp_task_pkg::*;

    localparam int depth = `STATION_DEPTH;
    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);
    localparam int crd_w = $clog2(`TASK_CREDITS + 1);

    task_t              entries [depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   count;
    logic [crd_w-1:0]   credits;
    logic               push;
    logic               issue;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign station_full = (count == cnt_w'(depth));
    assign rs_empty     = (count == '0);

    assign push = task_valid && !station_full;

    // oldest entry goes out whenever a PE credit is held
    assign issue         = !rs_empty && (credits != '0);
    assign pe_task_valid = issue;
    assign pe_task       = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= task_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= crd_w'(`TASK_CREDITS);
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (issue) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, issue})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // a returned credit and an issue in one cycle cancel
            case ({issue, pe_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/dp_top.sv ====
`default_nettype none

`include "gnn_dp_defines.svh"

module dp_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cmd_in_valid,
    input  dp_cmd_pkg::cmd_word_u   cmd_in,
    output logic                    cmd_credit,
    output logic                    pe_task_valid,
    output dp_task_pkg::task_t      pe_task,
    input  logic                    pe_credit,
    output logic                    mem_req,
    input  logic                    grant,
    output logic                    mem_valid,
    output dp_task_pkg::mem_pkt_t   mem_pkt,
    input  logic [`NUM_PE-1:0]      bank_busy,
    input  logic [`NUM_PE-1:0]      pe_idle,
    input  logic                    stream_end,
    input  logic                    vertex_done,
    input  logic                    outbuff_available,
    output logic                    cntl_done,
    output logic                    task_complete,
    output logic                    stream_begin,
    output logic [1:0]              replay_iter,
    output logic [`FV_WIDTH-1:0]    num_fv,
    output logic [`WB_WIDTH-1:0]    weights_boundary
);
    import dp_cmd_pkg::*;
    import dp_task_pkg::*;

    logic      head_valid;
    cmd_word_u head_word;
    logic      pop;
    logic      task_valid;
    task_t     task_data;
    logic      station_full;
    logic      rs_empty;

    cmd_queue u_cmd_queue (
        .clk          (clk),
        .reset        (reset),
        .cmd_in_valid (cmd_in_valid),
        .cmd_in       (cmd_in),
        .cmd_credit   (cmd_credit),
        .head_valid   (head_valid),
        .head_word    (head_word),
        .pop          (pop)
    );

    dp_decoder u_dp_decoder (
        .clk               (clk),
        .reset             (reset),
        .head_valid        (head_valid),
        .head_word         (head_word),
        .pop               (pop),
        .station_full      (station_full),
        .rs_empty          (rs_empty),
        .task_valid        (task_valid),
        .task_data         (task_data),
        .mem_req           (mem_req),
        .grant             (grant),
        .mem_valid         (mem_valid),
        .mem_pkt           (mem_pkt),
        .bank_busy         (bank_busy),
        .pe_idle           (pe_idle),
        .stream_end        (stream_end),
        .vertex_done       (vertex_done),
        .outbuff_available (outbuff_available),
        .cntl_done         (cntl_done),
        .task_complete     (task_complete),
        .stream_begin      (stream_begin),
        .replay_iter       (replay_iter),
        .num_fv            (num_fv),
        .weights_boundary  (weights_boundary)
    );

    task_station u_task_station (
        .clk           (clk),
        .reset         (reset),
        .task_valid    (task_valid),
        .task_data     (task_data),
        .station_full  (station_full),
        .rs_empty      (rs_empty),
        .pe_task_valid (pe_task_valid),
        .pe_task       (pe_task),
        .pe_credit     (pe_credit)
    );

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // held for 16 rising edges, released just after the last one
    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== test/dp_top_props.sv ====
`default_nettype none

`include "gnn_dp_defines.svh"

module dp_top_props (
    input logic                  clk,
    input logic                  reset,
    input logic                  cmd_in_valid,
    input logic                  head_valid,
    input dp_cmd_pkg::cmd_word_u head_word,
    input logic                  pop,
    input logic                  station_full,
    input logic [1:0]            replay_iter,
    input logic                  mem_req,
    input logic                  grant,
    input logic                  cntl_done,
    input logic                  task_complete
);
    import dp_cmd_pkg::*;

    localparam int cnt_w = $clog2(`CMD_QUEUE_DEPTH + 1);

    logic [cnt_w-1:0] fill;
    logic             task_at_head;

    // a task for the current iteration, bound for the station
    assign task_at_head = head_valid && (head_word.task_view.op == op_task)
                          && head_word.task_view.iter_mask[replay_iter];

    // queue occupancy seen from the host side
    always_ff @(posedge clk) begin
        if (reset) begin
            fill <= '0;
        end else begin
            fill <= fill + cnt_w'(cmd_in_valid) - cnt_w'(pop && head_valid);
        end
    end

    req_until_grant: assert property (@(posedge clk) disable iff (reset)
        mem_req && !grant |=> mem_req)
        else $error("mem_req dropped before grant");

    no_pop_into_full_station: assert property (@(posedge clk) disable iff (reset)
        task_at_head && station_full |-> !pop)
        else $error("task popped while the station was full");

    no_write_into_full_queue: assert property (@(posedge clk) disable iff (reset)
        cmd_in_valid |-> fill < cnt_w'(`CMD_QUEUE_DEPTH))
        else $error("host wrote a command into a full queue");

    no_pop_at_done: assert property (@(posedge clk) disable iff (reset)
        cntl_done || task_complete |-> !pop)
        else $error("pop together with cntl_done or task_complete");

endmodule

bind dp_top dp_top_props u_props (
    .clk           (clk),
    .reset         (reset),
    .cmd_in_valid  (cmd_in_valid),
    .head_valid    (head_valid),
    .head_word     (head_word),
    .pop           (pop),
    .station_full  (station_full),
    .replay_iter   (replay_iter),
    .mem_req       (mem_req),
    .grant         (grant),
    .cntl_done     (cntl_done),
    .task_complete (task_complete)
);

`default_nettype wire

// ==== test/dp_top_tb.sv ====
`default_nettype none

`include "gnn_dp_defines.svh"

module dp_top_tb;
    import dp_cmd_pkg::*;
    import dp_task_pkg::*;

    localparam int num_cmds = 20;
    localparam int cycles_per_cmd = 60;
    localparam int wait_limit = 200;
    localparam int burst_tasks = 10;

    logic                 clk;
    logic                 reset;
    logic                 cmd_in_valid;
    cmd_word_u            cmd_in;
    logic                 cmd_credit;
    logic                 pe_task_valid;
    task_t                pe_task;
    logic                 pe_credit;
    logic                 mem_req;
    logic                 grant;
    logic                 mem_valid;
    mem_pkt_t             mem_pkt;
    logic [`NUM_PE-1:0]   bank_busy;
    logic [`NUM_PE-1:0]   pe_idle;
    logic                 stream_end;
    logic                 vertex_done;
    logic                 outbuff_available;
    logic                 cntl_done;
    logic                 task_complete;
    logic                 stream_begin;
    logic [1:0]           replay_iter;
    logic [`FV_WIDTH-1:0] num_fv;
    logic [`WB_WIDTH-1:0] weights_boundary;

    int    host_credits;
    int    pe_owed;
    bit    pe_hold;
    task_t pe_seen[$];
    task_t pe_expect[$];
    string test_name;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    dp_top dut (
        .clk               (clk),
        .reset             (reset),
        .cmd_in_valid      (cmd_in_valid),
        .cmd_in            (cmd_in),
        .cmd_credit        (cmd_credit),
        .pe_task_valid     (pe_task_valid),
        .pe_task           (pe_task),
        .pe_credit         (pe_credit),
        .mem_req           (mem_req),
        .grant             (grant),
        .mem_valid         (mem_valid),
        .mem_pkt           (mem_pkt),
        .bank_busy         (bank_busy),
        .pe_idle           (pe_idle),
        .stream_end        (stream_end),
        .vertex_done       (vertex_done),
        .outbuff_available (outbuff_available),
        .cntl_done         (cntl_done),
        .task_complete     (task_complete),
        .stream_begin      (stream_begin),
        .replay_iter       (replay_iter),
        .num_fv            (num_fv),
        .weights_boundary  (weights_boundary)
    );

    // host side credit counter
    always @(posedge clk) begin
        if (reset) begin
            host_credits <= `CMD_QUEUE_DEPTH;
        end else begin
            host_credits <= host_credits + int'(cmd_credit) - int'(cmd_in_valid);
        end
    end

    // PE array: logs issued tasks, one credit back per task unless held
    always @(posedge clk) begin
        if (reset) begin
            pe_owed <= 0;
        end else begin
            if (pe_task_valid) begin
                pe_seen.push_back(pe_task);
            end
            pe_owed <= pe_owed + int'(pe_task_valid) - int'(pe_credit);
        end
        #1;
        pe_credit = !pe_hold && (pe_owed > 0);
    end

    initial begin
        repeat (16 + num_cmds * cycles_per_cmd) @(posedge clk);
        $display("watchdog expired, the tests did not finish in time");
        $display("TEST FAILED");
        $fatal(1);
    end

    function automatic logic [31:0] task_word(logic [3:0] mask, logic [25:0] payload);
        return {2'b00, payload[25:10], mask, payload[9:0]};
    endfunction

    function automatic logic [31:0] cfg_word(logic [1:0] op, logic [29:0] value);
        return {op, value};
    endfunction

    function automatic logic probe(string what);
        case (what)
            "mem_req":      return mem_req;
            "mem_valid":    return mem_valid;
            "stream_begin": return stream_begin;
            "cntl_done":    return cntl_done;
            default:        return 1'b0;
        endcase
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic fail_run(string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(string what, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %s %s expected 0x%0h actual 0x%0h",
                     test_name, what, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // returns on the edge where the signal is sampled high
    task automatic wait_for(string what);
        int n;
        n = 0;
        @(posedge clk);
        while (!probe(what)) begin
            n++;
            if (n > wait_limit) begin
                fail_run($sformatf("%s timed out waiting for %s", test_name, what));
            end
            @(posedge clk);
        end
    endtask

    task automatic wait_pe(int count);
        int n;
        n = 0;
        while (pe_seen.size() < count) begin
            n++;
            if (n > wait_limit) begin
                fail_run($sformatf("%s saw too few tasks at the PE port", test_name));
            end
            tick();
        end
    endtask

    task automatic send_word(logic [31:0] w);
        int n;
        n = 0;
        while (host_credits == 0) begin
            n++;
            if (n > wait_limit) begin
                fail_run("host never got a command credit back");
            end
            tick();
        end
        cmd_in_valid = 1'b1;
        cmd_in = w;
        tick();
        cmd_in_valid = 1'b0;
    endtask

    task automatic grant_after(int delay, logic [31:0] expected);
        wait_for("mem_req");
        #1;
        repeat (delay) begin
            @(posedge clk);
            check_eq("mem_req held", 1, mem_req);
            check_eq("mem_valid before grant", 0, mem_valid);
            check_eq("no pop before grant", 0, cmd_credit);
            check_eq("stream_begin before grant", 0, stream_begin);
            #1;
        end
        grant = 1'b1;
        @(posedge clk);
        check_eq("mem_valid at grant", 1, mem_valid);
        check_eq("mem_pkt", expected, mem_pkt);
        #1;
        grant = 1'b0;
    endtask

    task automatic end_stream();
        stream_end = 1'b1;
        tick();
        stream_end = 1'b0;
    endtask

    // decoder held in a wait state, nothing may move
    task automatic hold_quiet(int cycles);
        repeat (3) tick();
        repeat (cycles) begin
            @(posedge clk);
            check_eq("no pop while held", 0, cmd_credit);
            check_eq("no stream_begin while held", 0, stream_begin);
            check_eq("no mem_valid while held", 0, mem_valid);
            #1;
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (host_credits < `CMD_QUEUE_DEPTH || pe_owed != 0) begin
            n++;
            if (n > wait_limit) begin
                fail_run($sformatf("%s left credits outstanding", test_name));
            end
            tick();
        end
        check_eq("host credits", `CMD_QUEUE_DEPTH, host_credits);
    endtask

    task automatic test_task_issue();
        logic [31:0] w;
        int          i;
        test_name = "task_issue";
        pe_hold = 1'b1;
        pe_seen.delete();
        pe_expect.delete();
        for (i = 0; i < burst_tasks; i++) begin
            w = task_word(4'b0001 | 4'($urandom % 16), 26'($urandom));
            pe_expect.push_back(w[29:0]);
            send_word(w);
        end
        wait_pe(`TASK_CREDITS);
        repeat (20) tick();
        check_eq("tasks issued without credit", `TASK_CREDITS, pe_seen.size());
        // the rest stays in the queue behind a full station
        check_eq("words held by a full station",
                 `CMD_QUEUE_DEPTH - (burst_tasks - `TASK_CREDITS - `STATION_DEPTH),
                 host_credits);
        pe_hold = 1'b0;
        wait_pe(burst_tasks);
        for (i = 0; i < burst_tasks; i++) begin
            check_eq($sformatf("pe_task %0d", i), pe_expect[i], pe_seen[i]);
        end
        drain();
    endtask

    task automatic test_deferred();
        logic [31:0]          w;
        logic [`FV_WIDTH-1:0] fv;
        test_name = "deferred";
        w = task_word(4'b1110, 26'($urandom));
        fv = `FV_WIDTH'(1 + $urandom % 31);
        send_word(w);
        send_word(cfg_word(2'b10, 30'(fv)));
        grant_after(2 + $urandom % 6, w);
        check_eq("num_fv before grant", 0, num_fv);
        wait_for("stream_begin");
        #1;
        check_eq("num_fv", fv, num_fv);
        @(posedge clk);
        check_eq("stream_begin single pulse", 0, stream_begin);
        #1;
        drain();
    endtask

    task automatic test_config();
        logic [`WB_WIDTH-1:0] wb;
        logic [`FV_WIDTH-1:0] fv;
        logic [`FV_WIDTH-1:0] old_fv;
        test_name = "config";
        wb = `WB_WIDTH'($urandom);
        old_fv = num_fv;
        fv = old_fv + 1'b1;
        // upper value bits are noise, only the low field counts
        send_word(cfg_word(2'b11, {26'($urandom), wb}));
        send_word(cfg_word(2'b10, {25'($urandom), fv}));
        hold_quiet(8);
        check_eq("weights_boundary", wb, weights_boundary);
        check_eq("num_fv during stream wait", old_fv, num_fv);
        end_stream();
        wait_for("stream_begin");
        #1;
        check_eq("num_fv", fv, num_fv);
        @(posedge clk);
        check_eq("stream_begin single pulse", 0, stream_begin);
        #1;
        drain();
    endtask

    task automatic test_replay();
        logic [31:0] r;
        logic [31:0] hit;
        logic [31:0] miss;
        test_name = "replay";
        r = cfg_word(2'b01, 30'($urandom));
        // banks busy alone, then one PE busy alone
        bank_busy = 4'b0100;
        pe_idle = '1;
        send_word(r);
        hold_quiet(6);
        bank_busy = '0;
        pe_idle = 4'b1101;
        hold_quiet(6);
        check_eq("replay_iter while held", 0, replay_iter);
        pe_idle = '1;
        wait_for("mem_valid");
        check_eq("replay mem_pkt", r, mem_pkt);
        #1;
        check_eq("replay_iter", 1, replay_iter);
        end_stream();
        // iteration 1 now picks mask bit 1
        pe_seen.delete();
        hit = task_word(4'b0010, 26'($urandom));
        miss = task_word(4'b1101, 26'($urandom));
        send_word(hit);
        wait_pe(1);
        check_eq("task routed on iteration 1", hit[29:0], pe_seen[0]);
        send_word(miss);
        grant_after($urandom % 4, miss);
        drain();
    endtask

    task automatic test_done();
        logic [31:0] r;
        int          k;
        test_name = "done";
        for (k = 2; k < `MAX_REPLAY_ITER; k++) begin
            r = cfg_word(2'b01, 30'($urandom));
            send_word(r);
            wait_for("mem_valid");
            check_eq("replay mem_pkt", r, mem_pkt);
            #1;
            check_eq("replay_iter", k, replay_iter);
            end_stream();
        end
        send_word(cfg_word(2'b01, 30'($urandom)));
        wait_for("cntl_done");
        check_eq("mem_valid on last replay", 0, mem_valid);
        check_eq("replay_iter at done", `MAX_REPLAY_ITER - 1, replay_iter);
        #1;
        vertex_done = 1'b1;
        repeat (3) begin
            @(posedge clk);
            check_eq("cntl_done single pulse", 0, cntl_done);
            check_eq("task_complete without outbuff", 0, task_complete);
            #1;
        end
        outbuff_available = 1'b1;
        @(posedge clk);
        check_eq("task_complete", 1, task_complete);
        #1;
        vertex_done = 1'b0;
        @(posedge clk);
        check_eq("task_complete without vertex_done", 0, task_complete);
        #1;
        drain();
    endtask

    initial begin
        void'($urandom(98));
        cmd_in_valid = 1'b0;
        cmd_in = '0;
        pe_credit = 1'b0;
        pe_hold = 1'b0;
        grant = 1'b0;
        bank_busy = '0;
        pe_idle = '1;
        stream_end = 1'b0;
        vertex_done = 1'b0;
        outbuff_available = 1'b0;
        test_name = "reset";
        @(negedge reset);
        @(posedge clk);
        check_eq("cmd_credit", 0, cmd_credit);
        check_eq("mem_req", 0, mem_req);
        check_eq("mem_valid", 0, mem_valid);
        check_eq("pe_task_valid", 0, pe_task_valid);
        check_eq("cntl_done", 0, cntl_done);
        check_eq("task_complete", 0, task_complete);
        check_eq("stream_begin", 0, stream_begin);
        #1;
        test_task_issue();
        test_deferred();
        test_config();
        test_replay();
        test_done();
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+hw
hw/dp_cmd_pkg.sv
hw/dp_task_pkg.sv
hw/cmd_queue.sv
hw/dp_decoder.sv
hw/task_station.sv
hw/dp_top.sv
test/tb_clock_gen.sv
test/dp_top_props.sv
test/dp_top_tb.sv

// ==== Bender.yml ====
package:
  name: gnn_dp

sources:
  - include_dirs:
      - hw
    files:
      - hw/dp_cmd_pkg.sv
      - hw/dp_task_pkg.sv
      - hw/cmd_queue.sv
      - hw/dp_decoder.sv
      - hw/task_station.sv
      - hw/dp_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/tb_clock_gen.sv
      - test/dp_top_props.sv
      - test/dp_top_tb.sv
